// File: hw/periph_pkg.sv
// Peripheral subsystem package
// Holds the response opcode encoding shared by the target, the request
// FIFO block, the top level and the testbench, plus the default widths
// and sizes that the top level hands down to its children

package periph_pkg;

  // Response opcode returned with every r_valid pulse
  // RESP_OK means the access was performed on the register bank
  // RESP_ERR flags an address outside the bank, nothing was touched
  typedef enum logic {
    RESP_OK  = 1'b0,
    RESP_ERR = 1'b1
  } resp_opc_e;

  // Request address width in bits
  localparam int DEF_ADDR_WIDTH = 32;

  // Data width in bits, byte enables are DATA_WIDTH/8 wide
  localparam int DEF_DATA_WIDTH = 32;

  // Number of entries in the request decoupling FIFO
  localparam int DEF_FIFO_DEPTH = 2;

  // Number of 32-bit registers in the peripheral target
  localparam int DEF_NUM_REGS = 16;

  // Cycles the target holds its grant low after each accepted access
  localparam int DEF_BUSY_CYCLES = 3;

endpackage

// File: hw/generic_fifo.sv
// Generic synchronous FIFO
// Circular buffer with a valid/grant handshake on both sides. Input is
// granted while the buffer is not full, the head entry is presented while
// it is not empty. Storage is registered, so there is no fall-through.

module generic_fifo #(
  parameter int DATA_WIDTH = 32,
  parameter int DATA_DEPTH = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Write side
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  valid_i,
  output logic                  grant_o,
  // Read side
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  valid_o,
  input  logic                  grant_i
);

  // Pointers need at least one bit even for a single-entry FIFO
  localparam int PTR_WIDTH = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
  // Occupancy must be able to hold the value DATA_DEPTH itself
  localparam int CNT_WIDTH = $clog2(DATA_DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem_q [DATA_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr_q;
  logic [PTR_WIDTH-1:0]  rd_ptr_q;
  logic [CNT_WIDTH-1:0]  count_q;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (count_q == CNT_WIDTH'(DATA_DEPTH));
  assign empty = (count_q == '0);

  // A full FIFO refuses the push even when the head leaves in the same cycle
  assign grant_o = ~full;
  assign valid_o = ~empty;

  assign push = valid_i & grant_o;
  assign pop  = valid_o & grant_i;

  // Head entry is always driven, it only matters while valid_o is high
  assign data_o = mem_q[rd_ptr_q];

  // Pointer and occupancy bookkeeping
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap explicitly so non power-of-two depths work too
        if (wr_ptr_q == PTR_WIDTH'(DATA_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr_q == PTR_WIDTH'(DATA_DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Occupancy only moves when exactly one side transfers
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array, written at the tail on every accepted push
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: hw/periph_fifo.sv
// Peripheral request FIFO
// Packs address, write enable, write data and byte enables into a single
// word and buffers it in a generic_fifo to decouple the core from a slow
// target. Responses are forwarded untouched, their latency is unchanged.

module periph_fifo #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Core side request
  input  logic                        data_req_i,
  input  logic [ADDR_WIDTH-1:0]       data_add_i,
  input  logic                        data_wen_i,
  input  logic [DATA_WIDTH-1:0]       data_wdata_i,
  input  logic [DATA_WIDTH/8-1:0]     data_be_i,
  output logic                        data_gnt_o,
  // Target side request
  output logic                        data_req_o,
  output logic [ADDR_WIDTH-1:0]       data_add_o,
  output logic                        data_wen_o,
  output logic [DATA_WIDTH-1:0]       data_wdata_o,
  output logic [DATA_WIDTH/8-1:0]     data_be_o,
  input  logic                        data_gnt_i,
  // Target side response
  input  logic                        data_r_valid_i,
  input  periph_pkg::resp_opc_e       data_r_opc_i,
  input  logic [DATA_WIDTH-1:0]       data_r_rdata_i,
  // Core side response
  output logic                        data_r_valid_o,
  output periph_pkg::resp_opc_e       data_r_opc_o,
  output logic [DATA_WIDTH-1:0]       data_r_rdata_o
);

  localparam int BE_WIDTH = DATA_WIDTH / 8;
  // One FIFO word carries the whole request, address in the top bits
  localparam int FIFO_DW  = ADDR_WIDTH + 1 + DATA_WIDTH + BE_WIDTH;

  logic [FIFO_DW-1:0] req_word_in;
  logic [FIFO_DW-1:0] req_word_out;

  assign req_word_in = {data_add_i, data_wen_i, data_wdata_i, data_be_i};
  assign {data_add_o, data_wen_o, data_wdata_o, data_be_o} = req_word_out;

  generic_fifo #(
    .DATA_WIDTH (FIFO_DW),
    .DATA_DEPTH (FIFO_DEPTH)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (req_word_in),
    .valid_i (data_req_i),
    .grant_o (data_gnt_o),
    .data_o  (req_word_out),
    .valid_o (data_req_o),
    .grant_i (data_gnt_i)
  );

  // Responses have no back-pressure, so they skip the buffer entirely
  assign data_r_valid_o = data_r_valid_i;
  assign data_r_opc_o   = data_r_opc_i;
  assign data_r_rdata_o = data_r_rdata_i;

endmodule

// File: hw/periph_regfile.sv
// Peripheral register bank target
// Word-addressed registers with byte-enable writes and range checking.
// Each accepted access answers one cycle later and then stalls the grant
// for a fixed number of cycles to model a slow peripheral.

module periph_regfile #(
  parameter int ADDR_WIDTH  = 32,
  parameter int DATA_WIDTH  = 32,
  parameter int NUM_REGS    = 16,
  parameter int BUSY_CYCLES = 3
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Request
  input  logic                    req_i,
  input  logic [ADDR_WIDTH-1:0]   add_i,
  input  logic                    wen_i,
  input  logic [DATA_WIDTH-1:0]   wdata_i,
  input  logic [DATA_WIDTH/8-1:0] be_i,
  output logic                    gnt_o,
  // Response
  output logic                    r_valid_o,
  output periph_pkg::resp_opc_e   r_opc_o,
  output logic [DATA_WIDTH-1:0]   r_rdata_o
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  localparam int BE_WIDTH  = DATA_WIDTH / 8;
  localparam int IDX_WIDTH = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
  // Counter holds BUSY_CYCLES-1 down to zero
  localparam int CNT_WIDTH = (BUSY_CYCLES > 1) ? $clog2(BUSY_CYCLES) : 1;

  state_e                 state_q;
  logic [CNT_WIDTH-1:0]   busy_cnt_q;
  logic [DATA_WIDTH-1:0]  regs_q [NUM_REGS];

  logic                   access;
  logic [IDX_WIDTH-1:0]   idx;
  logic                   upper_zero;
  logic                   in_range;

  logic                   r_valid_q;
  periph_pkg::resp_opc_e  r_opc_q;
  logic [DATA_WIDTH-1:0]  r_rdata_q;

  // The target only listens while idle
  assign gnt_o  = (state_q == ST_IDLE);
  assign access = req_i & gnt_o;

  // Byte offset bits [1:0] are ignored, the word index sits right above
  assign idx        = add_i[IDX_WIDTH+1:2];
  assign upper_zero = ~|add_i[ADDR_WIDTH-1:IDX_WIDTH+2];
  assign in_range   = upper_zero && (int'(idx) < NUM_REGS);

  // Stall FSM, a single access sends it busy for BUSY_CYCLES cycles
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      busy_cnt_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (access && (BUSY_CYCLES > 0)) begin
            state_q    <= ST_BUSY;
            busy_cnt_q <= CNT_WIDTH'(BUSY_CYCLES - 1);
          end
        end
        ST_BUSY: begin
          if (busy_cnt_q == '0) begin
            state_q <= ST_IDLE;
          end else begin
            busy_cnt_q <= busy_cnt_q - 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Register bank, only enabled bytes of an in-range write change
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (access && in_range && !wen_i) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (be_i[b]) begin
          regs_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Response strobe lasts exactly one cycle after the accepting edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= access;
    end
  end

  // Response payload is captured alongside the strobe
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (!in_range) begin
        r_opc_q   <= periph_pkg::RESP_ERR;
        r_rdata_q <= '0;
      end else if (!wen_i) begin
        // Writes acknowledge with zero data
        r_opc_q   <= periph_pkg::RESP_OK;
        r_rdata_q <= '0;
      end else begin
        r_opc_q   <= periph_pkg::RESP_OK;
        r_rdata_q <= regs_q[idx];
      end
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_opc_o   = r_opc_q;
  assign r_rdata_o = r_rdata_q;

endmodule

// File: hw/periph_subsystem.sv
// Peripheral access subsystem
// Core-side requests enter a small decoupling FIFO and are served by a
// stalling register bank target. Responses return in order, one per
// accepted request, straight back to the core side.

module periph_subsystem #(
  parameter int ADDR_WIDTH  = periph_pkg::DEF_ADDR_WIDTH,
  parameter int DATA_WIDTH  = periph_pkg::DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = periph_pkg::DEF_FIFO_DEPTH,
  parameter int NUM_REGS    = periph_pkg::DEF_NUM_REGS,
  parameter int BUSY_CYCLES = periph_pkg::DEF_BUSY_CYCLES
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Core side request, data_wen_i low means write
  input  logic                    data_req_i,
  input  logic [ADDR_WIDTH-1:0]   data_add_i,
  input  logic                    data_wen_i,
  input  logic [DATA_WIDTH-1:0]   data_wdata_i,
  input  logic [DATA_WIDTH/8-1:0] data_be_i,
  output logic                    data_gnt_o,
  // Core side response
  output logic                    data_r_valid_o,
  output periph_pkg::resp_opc_e   data_r_opc_o,
  output logic [DATA_WIDTH-1:0]   data_r_rdata_o
);

  // Request path between FIFO and target
  logic                    per_req;
  logic [ADDR_WIDTH-1:0]   per_add;
  logic                    per_wen;
  logic [DATA_WIDTH-1:0]   per_wdata;
  logic [DATA_WIDTH/8-1:0] per_be;
  logic                    per_gnt;
  // Response path from target back through the FIFO block
  logic                    per_r_valid;
  periph_pkg::resp_opc_e   per_r_opc;
  logic [DATA_WIDTH-1:0]   per_r_rdata;

  periph_fifo #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_periph_fifo (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .data_req_i     (data_req_i),
    .data_add_i     (data_add_i),
    .data_wen_i     (data_wen_i),
    .data_wdata_i   (data_wdata_i),
    .data_be_i      (data_be_i),
    .data_gnt_o     (data_gnt_o),
    .data_req_o     (per_req),
    .data_add_o     (per_add),
    .data_wen_o     (per_wen),
    .data_wdata_o   (per_wdata),
    .data_be_o      (per_be),
    .data_gnt_i     (per_gnt),
    .data_r_valid_i (per_r_valid),
    .data_r_opc_i   (per_r_opc),
    .data_r_rdata_i (per_r_rdata),
    .data_r_valid_o (data_r_valid_o),
    .data_r_opc_o   (data_r_opc_o),
    .data_r_rdata_o (data_r_rdata_o)
  );

  periph_regfile #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (DATA_WIDTH),
    .NUM_REGS    (NUM_REGS),
    .BUSY_CYCLES (BUSY_CYCLES)
  ) i_periph_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (per_req),
    .add_i     (per_add),
    .wen_i     (per_wen),
    .wdata_i   (per_wdata),
    .be_i      (per_be),
    .gnt_o     (per_gnt),
    .r_valid_o (per_r_valid),
    .r_opc_o   (per_r_opc),
    .r_rdata_o (per_r_rdata)
  );

endmodule

// File: testbench/tb_periph_subsystem.sv
// Testbench for the peripheral access subsystem
// Drives random reads and writes, in range and out of range, into the core-side
// port and checks every response in order against a reference register model

module tb_periph_subsystem;

  localparam int ADDR_WIDTH  = periph_pkg::DEF_ADDR_WIDTH;
  localparam int DATA_WIDTH  = periph_pkg::DEF_DATA_WIDTH;
  localparam int FIFO_DEPTH  = periph_pkg::DEF_FIFO_DEPTH;
  localparam int NUM_REGS    = periph_pkg::DEF_NUM_REGS;
  localparam int BUSY_CYCLES = periph_pkg::DEF_BUSY_CYCLES;
  localparam int BE_WIDTH    = DATA_WIDTH / 8;
  localparam int NUM_TRANS   = 400;
  localparam int CLK_PERIOD  = 100;
  // Each access may wait behind a full FIFO and the target stall, sweeps and reset add margin
  localparam int TIMEOUT = (NUM_TRANS + 2 * NUM_REGS) * (BUSY_CYCLES + 2 + FIFO_DEPTH)
                           * CLK_PERIOD + 100 * CLK_PERIOD;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  data_req_i;
  logic [ADDR_WIDTH-1:0] data_add_i;
  logic                  data_wen_i;
  logic [DATA_WIDTH-1:0] data_wdata_i;
  logic [BE_WIDTH-1:0]   data_be_i;
  logic                  data_gnt_o;
  logic                  data_r_valid_o;
  periph_pkg::resp_opc_e data_r_opc_o;
  logic [DATA_WIDTH-1:0] data_r_rdata_o;

  integer seed;
  int     error_cnt  = 0;
  int     accept_cnt = 0;
  int     resp_cnt   = 0;
  int     stall_cnt  = 0;

  // Reference register bank and the responses still owed, oldest first
  logic [DATA_WIDTH-1:0] model_mem [NUM_REGS];
  periph_pkg::resp_opc_e exp_opc_q [$];
  logic [DATA_WIDTH-1:0] exp_data_q [$];
  periph_pkg::resp_opc_e exp_opc;
  logic [DATA_WIDTH-1:0] exp_data;

  periph_subsystem #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .NUM_REGS    (NUM_REGS),
    .BUSY_CYCLES (BUSY_CYCLES)
  ) i_periph_subsystem (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .data_req_i     (data_req_i),
    .data_add_i     (data_add_i),
    .data_wen_i     (data_wen_i),
    .data_wdata_i   (data_wdata_i),
    .data_be_i      (data_be_i),
    .data_gnt_o     (data_gnt_o),
    .data_r_valid_o (data_r_valid_o),
    .data_r_opc_o   (data_r_opc_o),
    .data_r_rdata_o (data_r_rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Works out the response the bank owes for one accepted request
  task automatic predict_response(input logic [ADDR_WIDTH-1:0] addr, input logic wen,
                                  input logic [DATA_WIDTH-1:0] wdata,
                                  input logic [BE_WIDTH-1:0] be);
    logic [ADDR_WIDTH-1:0] word;
    int                    idx;
    word = addr >> 2;
    // Any set bit above the word index pushes the address past the bank
    if (word >= ADDR_WIDTH'(NUM_REGS)) begin
      exp_opc_q.push_back(periph_pkg::RESP_ERR);
      exp_data_q.push_back('0);
    end else begin
      idx = int'(word);
      if (!wen) begin
        for (int b = 0; b < BE_WIDTH; b++) begin
          if (be[b]) begin
            model_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
          end
        end
        exp_opc_q.push_back(periph_pkg::RESP_OK);
        exp_data_q.push_back('0);
      end else begin
        exp_opc_q.push_back(periph_pkg::RESP_OK);
        exp_data_q.push_back(model_mem[idx]);
      end
    end
  endtask

  // Holds one request on the core side until the FIFO grants it
  task automatic do_access(input logic [ADDR_WIDTH-1:0] addr, input logic wen,
                           input logic [DATA_WIDTH-1:0] wdata,
                           input logic [BE_WIDTH-1:0] be);
    data_req_i   <= 1'b1;
    data_add_i   <= addr;
    data_wen_i   <= wen;
    data_wdata_i <= wdata;
    data_be_i    <= be;
    @(posedge clk_i);
    while (data_gnt_o !== 1'b1) @(posedge clk_i);
    predict_response(addr, wen, wdata, be);
    accept_cnt++;
  endtask

  // Reads every register of the bank back to back
  task automatic sweep_reads();
    for (int i = 0; i < NUM_REGS; i++) begin
      do_access(ADDR_WIDTH'(i * 4), 1'b1, '0, '0);
    end
  endtask

  // Roughly 80% of addresses hit the bank, the rest overrun the index or set upper bits
  task automatic random_access();
    logic [31:0]           r;
    int unsigned           sel;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    r = $random(seed);
    sel = r % 10;
    r = $random(seed);
    if (sel < 8) begin
      addr = ADDR_WIDTH'((r % NUM_REGS) * 4);
    end else if (sel == 8) begin
      addr = ADDR_WIDTH'((NUM_REGS + r % 64) * 4);
    end else begin
      addr = ADDR_WIDTH'(r);
      addr[ADDR_WIDTH-1] = 1'b1;
    end
    r = $random(seed);
    // The byte offset bits are ignored by the target, so they can be anything
    addr[1:0] = r[1:0];
    wdata = $random(seed);
    do_access(addr, r[2], wdata, r[3 +: BE_WIDTH]);
  endtask

  // Response checker, also counts cycles where the FIFO pushes back on the core
  always @(posedge clk_i) begin
    if (data_req_i && !data_gnt_o) begin
      stall_cnt++;
    end
    if (data_r_valid_o) begin
      resp_cnt++;
      if (exp_opc_q.size() == 0) begin
        error_cnt++;
        $display("response arrived at time %0t while no request was outstanding", $time);
      end else begin
        exp_opc  = exp_opc_q.pop_front();
        exp_data = exp_data_q.pop_front();
        if (data_r_opc_o !== exp_opc) begin
          error_cnt++;
          $display("mismatch at time %0t: data_r_opc_o expected %0d, got %0d",
                   $time, exp_opc, data_r_opc_o);
        end
        if (data_r_rdata_o !== exp_data) begin
          error_cnt++;
          $display("mismatch at time %0t: data_r_rdata_o expected %h, got %h",
                   $time, exp_data, data_r_rdata_o);
        end
      end
    end
  end

  initial begin
    logic [31:0] r;
    seed = 32'h097c6fb0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_mem[i] = '0;
    end
    rst_n_i      <= 1'b0;
    data_req_i   <= 1'b0;
    data_add_i   <= '0;
    data_wen_i   <= 1'b1;
    data_wdata_i <= '0;
    data_be_i    <= '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    if (data_gnt_o !== 1'b1) begin
      error_cnt++;
      $display("mismatch at time %0t: data_gnt_o expected 1, got %b", $time, data_gnt_o);
    end
    if (data_r_valid_o !== 1'b0) begin
      error_cnt++;
      $display("mismatch at time %0t: data_r_valid_o expected 0, got %b", $time, data_r_valid_o);
    end
    // Untouched bank must read back as all zero
    sweep_reads();
    repeat (NUM_TRANS) begin
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        data_req_i <= 1'b0;
        @(posedge clk_i);
      end
      random_access();
    end
    // Final sweep shows whether any error access leaked into the bank
    sweep_reads();
    data_req_i <= 1'b0;
    while (exp_opc_q.size() != 0) @(posedge clk_i);
    // Quiet period catches any response nobody asked for
    repeat (2 * (BUSY_CYCLES + 2)) @(posedge clk_i);
    if (resp_cnt != accept_cnt) begin
      error_cnt++;
      $display("%0d requests were accepted but %0d responses came back", accept_cnt, resp_cnt);
    end
    if (stall_cnt == 0) begin
      error_cnt++;
      $display("data_gnt_o never dropped although requests came back to back");
    end
    $display("errors: %0d, accepted: %0d, responses: %0d, stall cycles: %0d",
             error_cnt, accept_cnt, resp_cnt, stall_cnt);
    if (error_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog in case the DUT stops granting or stops responding
  initial begin
    #(TIMEOUT);
    $display("timeout after %0d time units, the run did not drain", TIMEOUT);
    $display("errors: %0d, accepted: %0d, responses: %0d", error_cnt, accept_cnt, resp_cnt);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog.f
hw/periph_pkg.sv
hw/generic_fifo.sv
hw/periph_fifo.sv
hw/periph_regfile.sv
hw/periph_subsystem.sv
testbench/tb_periph_subsystem.sv

// File: Makefile
# Verilator build and run for the peripheral subsystem testbench

TOP = tb_periph_subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
